// File: design/cdr_pkg.sv
package cdr_pkg;

    // ADC and interpolator geometry
    localparam int N_ADC = 8;
    localparam int N_TI = 4;
    localparam int N_PI = 8;
    localparam int N_OUT = 4;

    // Mueller-Muller error carries two extra bits over the raw samples
    localparam int PD_W = N_ADC + 2;
    localparam int GAIN_W = 3;

    // Loop width follows the phase-estimate shift used by the top level
    localparam int PHASE_EST_SHIFT_DEF = 8;
    localparam int LOOP_W = PD_W + PHASE_EST_SHIFT_DEF;

    typedef logic signed [N_ADC-1:0] adc_sample_t;

    // Lane 0 holds the oldest sample of the frame
    typedef adc_sample_t [N_TI-1:0] adc_frame_t;

    typedef logic [N_PI-1:0] pi_code_t;
    typedef pi_code_t [N_OUT-1:0] pi_ctl_bus_t;

    typedef struct packed {
        logic [GAIN_W-1:0]      kp;
        logic [GAIN_W-1:0]      ki;
        logic [GAIN_W-1:0]      kr;
        logic signed [PD_W-1:0] pd_offset;
        logic                   en_freq_est;
        logic                   en_ramp_est;
        logic                   en_ext_pi_ctl;
        logic [N_PI-1:0]        ext_pi_ctl;
    } cdr_cfg_t;

    typedef struct packed {
        logic signed [PD_W-1:0]   phase_est;
        logic signed [LOOP_W-1:0] freq_est;
        logic signed [LOOP_W-1:0] ramp_est;
    } cdr_snapshot_t;

    // Snapshot sampler wants a low request before it will arm
    typedef enum logic [1:0] {
        WAIT   = 2'd0,
        READY  = 2'd1,
        SAMPLE = 2'd2
    } sampler_state_e;

endpackage

// File: design/mm_phase_detector.sv
`timescale 1ns/1ps

module mm_phase_detector import cdr_pkg::*; (
    input  logic                   clk,
    input  logic                   ext_rstb,
    input  adc_frame_t             adc_frame_i,
    input  logic signed [PD_W-1:0] pd_offset_i,
    output logic signed [PD_W-1:0] phase_err_o
);

    // Sum of N_TI lane terms plus the offset fits here without wrapping
    localparam int SUM_W = PD_W + $clog2(N_TI) + 2;

    localparam logic signed [PD_W-1:0] PD_MAX = {1'b0, {(PD_W-1){1'b1}}};
    localparam logic signed [PD_W-1:0] PD_MIN = {1'b1, {(PD_W-1){1'b0}}};

    adc_sample_t             last_q;
    adc_frame_t              prev_frame;
    logic signed [SUM_W-1:0] pd_sum;
    logic signed [PD_W-1:0]  pd_sat;

    // sign(prev) * cur - sign(cur) * prev, zero counts as positive
    function automatic logic signed [SUM_W-1:0] mm_term(
        input adc_sample_t prev,
        input adc_sample_t cur
    );
        logic signed [SUM_W-1:0] p;
        logic signed [SUM_W-1:0] c;
        logic signed [SUM_W-1:0] t;
        p = prev;
        c = cur;
        t = prev[N_ADC-1] ? -c : c;
        t = cur[N_ADC-1] ? t + p : t - p;
        return t;
    endfunction

    // Each lane pairs with the sample before it, lane 0 with the kept one
    assign prev_frame = {adc_frame_i[N_TI-2:0], last_q};

    always_comb begin
        pd_sum = pd_offset_i;
        for (int i = 0; i < N_TI; i++) begin
            pd_sum = pd_sum + mm_term(prev_frame[i], adc_frame_i[i]);
        end
        if (pd_sum > PD_MAX) begin
            pd_sat = PD_MAX;
        end else if (pd_sum < PD_MIN) begin
            pd_sat = PD_MIN;
        end else begin
            pd_sat = pd_sum[PD_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            last_q      <= '0;
            phase_err_o <= '0;
        end else begin
            last_q      <= adc_frame_i[N_TI-1];
            phase_err_o <= pd_sat;
        end
    end

    // A sum beyond either rail must never wrap into the opposite sign
    a_no_wrap: assert property (@(posedge clk) disable iff (!ext_rstb)
        1'b1 |=> (phase_err_o[PD_W-1] == $past(pd_sum[SUM_W-1])));

endmodule

// File: design/cdr_loop_filter.sv
`timescale 1ns/1ps

module cdr_loop_filter import cdr_pkg::*; #(
    parameter int PHASE_EST_SHIFT = 8
) (
    input  logic                   clk,
    input  logic                   ext_rstb,
    input  logic signed [PD_W-1:0] phase_err_i,
    input  logic                   ramp_clock_i,
    input  cdr_cfg_t               cfg_i,
    output logic signed [PD_W-1:0] phase_est_o,
    output cdr_snapshot_t          loop_state_o,
    output logic                   freq_lvl_cross_o
);

    localparam int ACC_W = PD_W + PHASE_EST_SHIFT;

    logic signed [ACC_W-1:0] err_ext;
    logic signed [ACC_W-1:0] prop_term;
    logic signed [ACC_W-1:0] intg_term;
    logic signed [ACC_W-1:0] ramp_term;

    logic signed [ACC_W-1:0] ramp_pls_q;
    logic signed [ACC_W-1:0] ramp_neg_q;
    logic signed [ACC_W-1:0] ramp_pls_upd;
    logic signed [ACC_W-1:0] ramp_neg_upd;
    logic signed [ACC_W-1:0] ramp_sel_q;
    logic signed [ACC_W-1:0] ramp_sel_upd;

    logic signed [ACC_W-1:0] freq_q;
    logic signed [ACC_W-1:0] freq_upd;
    logic signed [ACC_W-1:0] prev_freq_upd_q;

    logic signed [ACC_W-1:0] phase_acc_q;
    logic signed [ACC_W-1:0] phase_acc_d;
    logic signed [ACC_W-1:0] phase_shifted;

    // Error is widened to the loop width before any gain shift
    assign err_ext   = phase_err_i;
    assign prop_term = err_ext <<< cfg_i.kp;
    assign intg_term = err_ext <<< cfg_i.ki;
    assign ramp_term = err_ext <<< cfg_i.kr;

    // The ramp clock phase decides which half of the ramp estimator integrates
    assign ramp_pls_upd = ramp_clock_i ? ramp_pls_q + ramp_term : ramp_pls_q;
    assign ramp_neg_upd = ramp_clock_i ? ramp_neg_q : ramp_neg_q + ramp_term;
    assign ramp_sel_q   = ramp_clock_i ? ramp_pls_q : ramp_neg_q;
    assign ramp_sel_upd = ramp_clock_i ? ramp_pls_upd : ramp_neg_upd;

    assign freq_upd = freq_q + intg_term + ramp_sel_q;

    // Phase integrates the proportional term on top of the stored frequency
    assign phase_acc_d   = phase_acc_q + prop_term + freq_q;
    assign phase_shifted = phase_acc_q >>> PHASE_EST_SHIFT;
    assign phase_est_o   = phase_shifted[PD_W-1:0];

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            ramp_pls_q <= '0;
            ramp_neg_q <= '0;
        end else if (!cfg_i.en_ramp_est) begin
            ramp_pls_q <= '0;
            ramp_neg_q <= '0;
        end else begin
            ramp_pls_q <= ramp_pls_upd;
            ramp_neg_q <= ramp_neg_upd;
        end
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            freq_q <= '0;
        end else if (cfg_i.en_freq_est) begin
            freq_q <= freq_upd;
        end else begin
            freq_q <= '0;
        end
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            phase_acc_q <= '0;
        end else begin
            phase_acc_q <= phase_acc_d;
        end
    end

    // Flag is high while the frequency update keeps rising
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            prev_freq_upd_q  <= '0;
            freq_lvl_cross_o <= 1'b0;
        end else begin
            prev_freq_upd_q  <= freq_upd;
            freq_lvl_cross_o <= (freq_upd > prev_freq_upd_q);
        end
    end

    assign loop_state_o = '{
        phase_est: phase_est_o,
        freq_est:  freq_upd,
        ramp_est:  ramp_sel_upd
    };

    // Disabling the ramp estimator flushes both halves on the next edge
    a_ramp_clear: assert property (@(posedge clk) disable iff (!ext_rstb)
        !cfg_i.en_ramp_est |=> (ramp_pls_q == '0 && ramp_neg_q == '0));

endmodule

// File: design/cdr_state_sampler.sv
`timescale 1ns/1ps

module cdr_state_sampler import cdr_pkg::*; (
    input  logic          clk,
    input  logic          ext_rstb,
    input  logic          sample_req_i,
    input  cdr_snapshot_t loop_state_i,
    output cdr_snapshot_t snapshot_o
);

    sampler_state_e state_q;

    // The request must drop before a new capture can be armed
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            state_q <= WAIT;
        end else begin
            case (state_q)
                WAIT: begin
                    if (!sample_req_i) begin
                        state_q <= READY;
                    end
                end
                READY: begin
                    if (sample_req_i) begin
                        state_q <= SAMPLE;
                    end
                end
                SAMPLE: begin
                    state_q <= WAIT;
                end
                default: begin
                    state_q <= WAIT;
                end
            endcase
        end
    end

    // Snapshot holds its value between captures
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            snapshot_o <= '0;
        end else if (state_q == SAMPLE) begin
            snapshot_o <= loop_state_i;
        end
    end

    a_snapshot_hold: assert property (@(posedge clk) disable iff (!ext_rstb)
        (state_q != SAMPLE) |=> $stable(snapshot_o));

endmodule

// File: design/pi_ctl_driver.sv
`timescale 1ns/1ps

module pi_ctl_driver import cdr_pkg::*; (
    input  logic                   clk,
    input  logic                   ext_rstb,
    input  logic signed [PD_W-1:0] phase_est_i,
    input  cdr_cfg_t               cfg_i,
    output pi_ctl_bus_t            pi_ctl_o
);

    logic signed [PD_W-1:0] phase_scaled;
    pi_code_t               code_sel;

    // Keep only the top N_PI bits of the phase estimate
    assign phase_scaled = phase_est_i >>> (PD_W - N_PI);

    assign code_sel = cfg_i.en_ext_pi_ctl ? cfg_i.ext_pi_ctl : phase_scaled[N_PI-1:0];

    // All interpolators get the same code
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            pi_ctl_o <= '0;
        end else begin
            for (int k = 0; k < N_OUT; k++) begin
                pi_ctl_o[k] <= code_sel;
            end
        end
    end

endmodule

// File: design/mm_cdr_top.sv
`timescale 1ns/1ps

module mm_cdr_top import cdr_pkg::*; #(
    parameter int PHASE_EST_SHIFT = 8
) (
    input  logic          clk,
    input  logic          ext_rstb,
    input  adc_frame_t    adc_frame_i,
    input  logic          ramp_clock_i,
    input  cdr_cfg_t      cfg_i,
    input  logic          sample_req_i,
    output pi_ctl_bus_t   pi_ctl_o,
    output logic          freq_lvl_cross_o,
    output cdr_snapshot_t snapshot_o
);

    logic signed [PD_W-1:0] phase_err;
    logic signed [PD_W-1:0] phase_est;
    cdr_snapshot_t          loop_state;

    mm_phase_detector u_mm_phase_detector (
        .clk         (clk),
        .ext_rstb    (ext_rstb),
        .adc_frame_i (adc_frame_i),
        .pd_offset_i (cfg_i.pd_offset),
        .phase_err_o (phase_err)
    );

    cdr_loop_filter #(
        .PHASE_EST_SHIFT (PHASE_EST_SHIFT)
    ) u_cdr_loop_filter (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .phase_err_i      (phase_err),
        .ramp_clock_i     (ramp_clock_i),
        .cfg_i            (cfg_i),
        .phase_est_o      (phase_est),
        .loop_state_o     (loop_state),
        .freq_lvl_cross_o (freq_lvl_cross_o)
    );

    cdr_state_sampler u_cdr_state_sampler (
        .clk          (clk),
        .ext_rstb     (ext_rstb),
        .sample_req_i (sample_req_i),
        .loop_state_i (loop_state),
        .snapshot_o   (snapshot_o)
    );

    pi_ctl_driver u_pi_ctl_driver (
        .clk         (clk),
        .ext_rstb    (ext_rstb),
        .phase_est_i (phase_est),
        .cfg_i       (cfg_i),
        .pi_ctl_o    (pi_ctl_o)
    );

endmodule

// File: testbench/tb_mm_cdr_top.sv
`timescale 1ns/1ps

module tb_mm_cdr_top import cdr_pkg::*; ();

    localparam int CLK_PERIOD      = 40;
    localparam int PHASE_EST_SHIFT = PHASE_EST_SHIFT_DEF;

    localparam int RESET_CYCLES    = 5;
    localparam int PROP_CYCLES     = 30;
    localparam int RAND_CYCLES     = 60;
    localparam int OVR_CYCLES      = 20;
    localparam int RESTORE_CYCLES  = 10;
    localparam int RISE_CYCLES     = 30;
    localparam int FALL_CYCLES     = 30;
    localparam int RAMP_CYCLES     = 40;
    localparam int RAMP_OFF_CYCLES = 10;
    localparam int SNAP_CYCLES     = 24;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + PROP_CYCLES + RAND_CYCLES + OVR_CYCLES
                                   + RESTORE_CYCLES + RISE_CYCLES + FALL_CYCLES + RAMP_CYCLES
                                   + RAMP_OFF_CYCLES + SNAP_CYCLES;
    localparam int WATCHDOG_CYCLES = TOTAL_CYCLES + TOTAL_CYCLES / 4 + 50;

    localparam int PD_HI = (1 << (PD_W - 1)) - 1;
    localparam int PD_LO = -(1 << (PD_W - 1));

    logic          clk;
    logic          ext_rstb;
    adc_frame_t    adc_frame_i;
    logic          ramp_clock_i;
    cdr_cfg_t      cfg_i;
    logic          sample_req_i;
    pi_ctl_bus_t   pi_ctl_o;
    logic          freq_lvl_cross_o;
    cdr_snapshot_t snapshot_o;

    logic [31:0] rng_state;
    logic        rise_window;
    logic        fall_window;
    logic        outputs_zero;

    // Reference model registers
    adc_sample_t              m_last;
    logic signed [PD_W-1:0]   m_err;
    logic signed [LOOP_W-1:0] m_rp;
    logic signed [LOOP_W-1:0] m_rn;
    logic signed [LOOP_W-1:0] m_freq;
    logic signed [LOOP_W-1:0] m_prev_upd;
    logic signed [LOOP_W-1:0] m_acc;
    logic                     m_cross;
    pi_ctl_bus_t              m_pi;
    sampler_state_e           m_state;
    cdr_snapshot_t            m_snap;

    // Values the model derives within the current cycle
    logic signed [LOOP_W-1:0] e_w;
    logic signed [LOOP_W-1:0] e_ramp;
    logic signed [LOOP_W-1:0] e_sel_q;
    logic signed [LOOP_W-1:0] e_sel_upd;
    logic signed [LOOP_W-1:0] e_upd;
    logic signed [LOOP_W-1:0] e_acc_sh;
    logic signed [PD_W-1:0]   e_phase;
    pi_code_t                 e_code;
    cdr_snapshot_t            e_state;

    mm_cdr_top #(
        .PHASE_EST_SHIFT (PHASE_EST_SHIFT)
    ) u_mm_cdr_top (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .adc_frame_i      (adc_frame_i),
        .ramp_clock_i     (ramp_clock_i),
        .cfg_i            (cfg_i),
        .sample_req_i     (sample_req_i),
        .pi_ctl_o         (pi_ctl_o),
        .freq_lvl_cross_o (freq_lvl_cross_o),
        .snapshot_o       (snapshot_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Mueller-Muller error of one frame, saturated to the detector range
    function automatic int mm_error(
        input adc_frame_t             frame,
        input adc_sample_t            last,
        input logic signed [PD_W-1:0] offset
    );
        int sum;
        int prev;
        int cur;
        int sp;
        int sc;
        sum = int'(offset);
        for (int i = 0; i < N_TI; i++) begin
            cur = int'($signed(frame[i]));
            if (i == 0) begin
                prev = int'(last);
            end else begin
                prev = int'($signed(frame[i-1]));
            end
            sp = (prev >= 0) ? 1 : -1;
            sc = (cur >= 0) ? 1 : -1;
            sum = sum + sp * cur - sc * prev;
        end
        if (sum > PD_HI) begin
            sum = PD_HI;
        end else if (sum < PD_LO) begin
            sum = PD_LO;
        end
        return sum;
    endfunction

    task automatic set_loop(
        input logic [GAIN_W-1:0]      kp,
        input logic [GAIN_W-1:0]      ki,
        input logic [GAIN_W-1:0]      kr,
        input logic signed [PD_W-1:0] offset,
        input logic                   en_freq,
        input logic                   en_ramp
    );
        cfg_i.kp          <= kp;
        cfg_i.ki          <= ki;
        cfg_i.kr          <= kr;
        cfg_i.pd_offset   <= offset;
        cfg_i.en_freq_est <= en_freq;
        cfg_i.en_ramp_est <= en_ramp;
    endtask

    task automatic drive_cycles(input int n, input bit random_frames, input bit toggle_ramp);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            if (random_frames) begin
                rng_state = xorshift32(rng_state);
                adc_frame_i <= rng_state;
            end else begin
                adc_frame_i <= '0;
            end
            if (toggle_ramp && (i % 3 == 2)) begin
                ramp_clock_i <= !ramp_clock_i;
            end
        end
    endtask

    always_comb begin
        e_w       = LOOP_W'(m_err);
        e_ramp    = e_w <<< cfg_i.kr;
        e_sel_q   = ramp_clock_i ? m_rp : m_rn;
        e_sel_upd = e_sel_q + e_ramp;
        e_upd     = m_freq + (e_w <<< cfg_i.ki) + e_sel_q;
        e_acc_sh  = m_acc >>> PHASE_EST_SHIFT;
        e_phase   = e_acc_sh[PD_W-1:0];
        e_code    = cfg_i.en_ext_pi_ctl ? cfg_i.ext_pi_ctl : e_phase[PD_W-1 -: N_PI];
        e_state   = '{phase_est: e_phase, freq_est: e_upd, ramp_est: e_sel_upd};
    end

    always @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            m_last     <= '0;
            m_err      <= '0;
            m_rp       <= '0;
            m_rn       <= '0;
            m_freq     <= '0;
            m_prev_upd <= '0;
            m_acc      <= '0;
            m_cross    <= 1'b0;
            m_pi       <= '0;
            m_state    <= WAIT;
            m_snap     <= '0;
        end else begin
            m_last <= adc_frame_i[N_TI-1];
            m_err  <= PD_W'(mm_error(adc_frame_i, m_last, cfg_i.pd_offset));
            if (!cfg_i.en_ramp_est) begin
                m_rp <= '0;
                m_rn <= '0;
            end else if (ramp_clock_i) begin
                m_rp <= m_rp + e_ramp;
            end else begin
                m_rn <= m_rn + e_ramp;
            end
            m_freq     <= cfg_i.en_freq_est ? e_upd : '0;
            m_acc      <= m_acc + (e_w <<< cfg_i.kp) + m_freq;
            m_prev_upd <= e_upd;
            m_cross    <= (e_upd > m_prev_upd);
            m_pi       <= {N_OUT{e_code}};
            case (m_state)
                WAIT: begin
                    if (!sample_req_i) begin
                        m_state <= READY;
                    end
                end
                READY: begin
                    if (sample_req_i) begin
                        m_state <= SAMPLE;
                    end
                end
                default: begin
                    m_state <= WAIT;
                end
            endcase
            if (m_state == SAMPLE) begin
                m_snap <= e_state;
            end
        end
    end

    assign outputs_zero = (pi_ctl_o == '0) && !freq_lvl_cross_o && (snapshot_o == '0);

    a_reset_zero: assert property (@(posedge clk) !ext_rstb |-> outputs_zero)
        else abort_run($sformatf(
            "ERROR: reset pi_ctl_o = %h, freq_lvl_cross_o = %h, snapshot_o = %h",
            $sampled(pi_ctl_o), $sampled(freq_lvl_cross_o), $sampled(snapshot_o)));

    // Outputs stay clear on the edge that releases reset and the one after it
    a_release_zero: assert property (@(posedge clk)
        $rose(ext_rstb) |-> outputs_zero ##1 outputs_zero)
        else abort_run($sformatf(
            "ERROR: after reset pi_ctl_o = %h, freq_lvl_cross_o = %h, snapshot_o = %h",
            $sampled(pi_ctl_o), $sampled(freq_lvl_cross_o), $sampled(snapshot_o)));

    a_pi_ctl: assert property (@(posedge clk) disable iff (!ext_rstb) pi_ctl_o == m_pi)
        else abort_run($sformatf("ERROR: pi_ctl_o = %h, expected %h",
            $sampled(pi_ctl_o), $sampled(m_pi)));

    a_override: assert property (@(posedge clk) disable iff (!ext_rstb)
        cfg_i.en_ext_pi_ctl |=> pi_ctl_o == {N_OUT{$past(cfg_i.ext_pi_ctl)}})
        else abort_run($sformatf("ERROR: pi_ctl_o = %h under override, expected %h",
            $sampled(pi_ctl_o), $sampled(m_pi)));

    a_cross: assert property (@(posedge clk) disable iff (!ext_rstb)
        freq_lvl_cross_o == m_cross)
        else abort_run($sformatf("ERROR: freq_lvl_cross_o = %h, expected %h",
            $sampled(freq_lvl_cross_o), $sampled(m_cross)));

    a_rising: assert property (@(posedge clk) disable iff (!ext_rstb)
        rise_window |-> freq_lvl_cross_o)
        else abort_run($sformatf("ERROR: freq_lvl_cross_o = %h, expected 1 with a positive offset",
            $sampled(freq_lvl_cross_o)));

    a_falling: assert property (@(posedge clk) disable iff (!ext_rstb)
        fall_window |-> !freq_lvl_cross_o)
        else abort_run($sformatf("ERROR: freq_lvl_cross_o = %h, expected 0 with a negative offset",
            $sampled(freq_lvl_cross_o)));

    a_snapshot: assert property (@(posedge clk) disable iff (!ext_rstb) snapshot_o == m_snap)
        else abort_run($sformatf("ERROR: snapshot_o = %h, expected %h",
            $sampled(snapshot_o), $sampled(m_snap)));

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("Timeout: the test sequence did not finish in the expected time");
    end

    initial begin
        clk          = 1'b0;
        ext_rstb    <= 1'b0;
        adc_frame_i  = '0;
        ramp_clock_i = 1'b0;
        cfg_i        = '0;
        sample_req_i = 1'b0;
        rise_window  = 1'b0;
        fall_window  = 1'b0;
        rng_state    = 32'hb2d0;

        repeat (RESET_CYCLES) @(posedge clk);
        ext_rstb <= 1'b1;

        // Zero frames leave only the offset as error
        set_loop(3'd4, 3'd0, 3'd0, 10'sd40, 1'b0, 1'b0);
        drive_cycles(PROP_CYCLES, 1'b0, 1'b0);
        set_loop(3'd1, 3'd0, 3'd0, 10'sd5, 1'b0, 1'b0);
        drive_cycles(RAND_CYCLES, 1'b1, 1'b0);

        cfg_i.en_ext_pi_ctl <= 1'b1;
        cfg_i.ext_pi_ctl    <= 8'ha5;
        drive_cycles(OVR_CYCLES / 2, 1'b1, 1'b0);
        cfg_i.ext_pi_ctl    <= 8'h3c;
        drive_cycles(OVR_CYCLES / 2, 1'b1, 1'b0);
        cfg_i.en_ext_pi_ctl <= 1'b0;
        drive_cycles(RESTORE_CYCLES, 1'b0, 1'b0);

        // The flag needs a few edges to see the new error through the detector
        set_loop(3'd2, 3'd1, 3'd0, 10'sd12, 1'b1, 1'b0);
        drive_cycles(4, 1'b0, 1'b0);
        rise_window <= 1'b1;
        drive_cycles(RISE_CYCLES - 4, 1'b0, 1'b0);
        rise_window <= 1'b0;
        cfg_i.pd_offset <= -10'sd12;
        drive_cycles(4, 1'b0, 1'b0);
        fall_window <= 1'b1;
        drive_cycles(FALL_CYCLES - 4, 1'b0, 1'b0);
        fall_window <= 1'b0;

        set_loop(3'd1, 3'd0, 3'd1, 10'sd6, 1'b1, 1'b1);
        drive_cycles(RAMP_CYCLES, 1'b1, 1'b1);
        cfg_i.en_ramp_est <= 1'b0;
        drive_cycles(RAMP_OFF_CYCLES, 1'b1, 1'b0);

        // One long request and one short one, each good for a single capture
        cfg_i.en_ramp_est <= 1'b1;
        drive_cycles(4, 1'b1, 1'b1);
        sample_req_i <= 1'b1;
        drive_cycles(8, 1'b1, 1'b1);
        sample_req_i <= 1'b0;
        drive_cycles(4, 1'b1, 1'b1);
        sample_req_i <= 1'b1;
        drive_cycles(3, 1'b1, 1'b1);
        sample_req_i <= 1'b0;
        drive_cycles(5, 1'b1, 1'b1);

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: mm_cdr_top.f
design/cdr_pkg.sv
design/mm_phase_detector.sv
design/cdr_loop_filter.sv
design/cdr_state_sampler.sv
design/pi_ctl_driver.sv
design/mm_cdr_top.sv
testbench/tb_mm_cdr_top.sv
